/* list.f */
source/bht_pkg.sv
source/bht_way.sv
source/bht_alloc.sv
source/bht_resolve.sv
source/bht_top.sv
tb/tb_bht.sv

/* tb/tb_bht.sv */
`timescale 1ns/10ps

module tb_bht import bht_pkg::*;
();

	logic CLK;
	logic rst;
	logic [pc_w-1:0] if_pc;
	logic [pc_w-1:0] id_pc;
	logic [pc_w-1:0] id_branchtarget;
	logic [pc_w-1:0] exe_pc;
	logic id_is_jump;
	logic id_is_btype;
	logic exe_z;
	logic exe_less;
	btype_t exe_btype;
	logic if_prediction;
	logic [pc_w-1:0] if_pbt;
	corr_t exe_correction;
	logic [pc_w-1:0] exe_pbt;
	logic [pc_w-1:0] exe_cni;
	logic flush;

	bht_top i_dut (.*);

	// 10 ns period
	always #5 CLK = ~CLK;

	//////////////////////////////
	// shadow table
	//////////////////////////////

	logic sh_valid [n_sets][n_ways];
	logic [tag_w-1:0] sh_tag [n_sets][n_ways];
	logic [pc_w-1:0] sh_target [n_sets][n_ways];
	logic [ctr_w-1:0] sh_ctr [n_sets][n_ways];
	logic [way_w-1:0] sh_ptr [n_sets];

	// expected responses for the current inputs
	logic exp_if_pred;
	logic [pc_w-1:0] exp_if_pbt;
	logic exp_id_hit;
	logic exp_exe_hit;
	logic [way_w-1:0] exp_exe_way;
	logic [ctr_w-1:0] exp_exe_ctr;
	logic [pc_w-1:0] exp_exe_pbt;
	logic exp_taken;
	logic exp_upd;
	logic exp_alloc;
	logic exp_drop;
	logic [way_w-1:0] exp_victim;
	corr_t exp_corr;
	logic [pc_w-1:0] exp_cni;

	int n_err_fetch;
	int n_err_exe;
	integer seed;

	// outcome rule per opcode
	function automatic logic branch_taken(input btype_t bt, input logic z, input logic less);
		if (bt == bt_beq) return z;
		if (bt == bt_bne) return !z;
		if (bt == bt_blt || bt == bt_bltu) return less;
		if (bt == bt_bge || bt == bt_bgeu) return !less;
		return 1'b0;
	endfunction

	// two bit saturating step
	function automatic logic [ctr_w-1:0] next_count(input logic [ctr_w-1:0] c, input logic tk);
		if (tk && c != 2'd3) return c + 2'd1;
		if (!tk && c != 2'd0) return c - 2'd1;
		return c;
	endfunction

	always_comb
	begin
		exp_if_pred = 1'b0;
		exp_if_pbt = '0;
		exp_id_hit = 1'b0;
		exp_exe_hit = 1'b0;
		exp_exe_way = '0;
		exp_exe_ctr = '0;
		exp_exe_pbt = '0;
		for (int w = 0; w < n_ways; w++)
		begin
			if (sh_valid[if_pc[3:0]][w] && sh_tag[if_pc[3:0]][w] == if_pc[9:4])
			begin
				exp_if_pred = sh_ctr[if_pc[3:0]][w][1];
				exp_if_pbt = sh_target[if_pc[3:0]][w];
			end
			if (sh_valid[id_pc[3:0]][w] && sh_tag[id_pc[3:0]][w] == id_pc[9:4])
				exp_id_hit = 1'b1;
			if (sh_valid[exe_pc[3:0]][w] && sh_tag[exe_pc[3:0]][w] == exe_pc[9:4])
			begin
				exp_exe_hit = 1'b1;
				exp_exe_way = w[way_w-1:0];
				exp_exe_ctr = sh_ctr[exe_pc[3:0]][w];
				exp_exe_pbt = sh_target[exe_pc[3:0]][w];
			end
		end
		exp_taken = branch_taken(exe_btype, exe_z, exe_less);
		exp_upd = exp_exe_hit && (exe_btype != bt_none);
		// wrong direction predicted at fetch
		if (exp_upd && (exp_exe_ctr[1] != exp_taken))
			exp_corr = exp_taken ? corr_pbt : corr_cni;
		else
			exp_corr = corr_none;
		exp_cni = exe_pc + 10'd4;
		exp_alloc = (id_is_jump || id_is_btype) && !exp_id_hit;
		exp_victim = sh_ptr[id_pc[3:0]];
		// a counter update on the victim slot wins
		exp_drop = exp_upd && (exp_exe_way == exp_victim) && (exe_pc[3:0] == id_pc[3:0]);
	end

	always @(posedge CLK)
	begin
		if (rst)
		begin
			for (int s = 0; s < n_sets; s++)
			begin
				sh_ptr[s] <= '0;
				for (int w = 0; w < n_ways; w++)
					sh_valid[s][w] <= 1'b0;
			end
		end
		else
		begin
			if (exp_upd)
				sh_ctr[exe_pc[3:0]][exp_exe_way] <= next_count(exp_exe_ctr, exp_taken);
			if (exp_alloc && !exp_drop)
			begin
				sh_valid[id_pc[3:0]][exp_victim] <= 1'b1;
				sh_tag[id_pc[3:0]][exp_victim] <= id_pc[9:4];
				sh_target[id_pc[3:0]][exp_victim] <= id_branchtarget;
				sh_ctr[id_pc[3:0]][exp_victim] <= id_is_jump ? ctr_init_jump : ctr_init_branch;
				sh_ptr[id_pc[3:0]] <= exp_victim + 2'd1;
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic report_mismatch(input string sig, input logic [31:0] expv,
		input logic [31:0] actv, input bit at_exe);
		$display("ERROR %s expected %0h actual %0h at %0t", sig, expv, actv, $time);
		if (at_exe)
			n_err_exe++;
		else
			n_err_fetch++;
	endtask

	a_if_prediction: assert property (@(posedge CLK) disable iff (rst)
		if_prediction == exp_if_pred)
		else report_mismatch("if_prediction", $sampled(exp_if_pred), $sampled(if_prediction), 0);
	a_if_pbt: assert property (@(posedge CLK) disable iff (rst) if_pbt == exp_if_pbt)
		else report_mismatch("if_pbt", $sampled(exp_if_pbt), $sampled(if_pbt), 0);
	a_correction: assert property (@(posedge CLK) disable iff (rst) exe_correction == exp_corr)
		else report_mismatch("exe_correction", $sampled(exp_corr), $sampled(exe_correction), 1);
	a_flush: assert property (@(posedge CLK) disable iff (rst)
		flush == (exp_corr != corr_none))
		else report_mismatch("flush", $sampled(exp_corr != corr_none), $sampled(flush), 1);
	a_cni: assert property (@(posedge CLK) disable iff (rst) exe_cni == exp_cni)
		else report_mismatch("exe_cni", $sampled(exp_cni), $sampled(exe_cni), 1);
	// target only defined on a hit
	a_exe_pbt: assert property (@(posedge CLK) disable iff (rst)
		exp_exe_hit |-> exe_pbt == exp_exe_pbt)
		else report_mismatch("exe_pbt", $sampled(exp_exe_pbt), $sampled(exe_pbt), 1);

	//////////////////////////////
	// stimulus
	//////////////////////////////

	btype_t bt_list [6] = '{bt_beq, bt_bne, bt_blt, bt_bge, bt_bltu, bt_bgeu};

	task automatic clear_inputs();
		if_pc = '0;
		id_pc = '0;
		id_branchtarget = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = bt_none;
	endtask

	task automatic decode_entry(input logic [pc_w-1:0] pc, input logic [pc_w-1:0] tgt,
		input logic jump);
		id_pc = pc;
		id_branchtarget = tgt;
		id_is_jump = jump;
		id_is_btype = !jump;
		@(negedge CLK);
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
	endtask

	task automatic resolve_branch(input logic [pc_w-1:0] pc, input btype_t bt, input logic z,
		input logic less);
		exe_pc = pc;
		exe_btype = bt;
		exe_z = z;
		exe_less = less;
		@(negedge CLK);
		exe_btype = bt_none;
	endtask

	task automatic fetch_at(input logic [pc_w-1:0] pc);
		if_pc = pc;
		@(negedge CLK);
	endtask

	// poll the fetch port until the entry shows up
	task automatic wait_fetch_target(input logic [pc_w-1:0] pc, input logic [pc_w-1:0] tgt);
		int n;
		n = 0;
		if_pc = pc;
		#2;
		while (if_pbt !== tgt && n < 8)
		begin
			@(negedge CLK);
			#2;
			n++;
		end
		if (if_pbt !== tgt)
		begin
			$display("timeout, no fetch hit at pc %h after %0d cycles", pc, n);
			n_err_fetch++;
		end
		@(negedge CLK);
	endtask

	logic [pc_w-1:0] pc_a;
	logic [pc_w-1:0] pc_b;
	logic [pc_w-1:0] tgt_a;
	logic [pc_w-1:0] ev_pc [5];
	logic [pc_w-1:0] pool [8];
	logic [tag_w-1:0] base;
	logic [31:0] r;

	initial
	begin
		CLK = 1'b0;
		rst = 1'b1;
		seed = 32'hf6d7_c1b5;
		n_err_fetch = 0;
		n_err_exe = 0;
		clear_inputs();
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;

		// empty table, everything misses
		for (int i = 0; i < 8; i++)
		begin
			exe_pc = 10'($random(seed));
			exe_btype = bt_list[i % 6];
			fetch_at(10'($random(seed)));
		end
		exe_btype = bt_none;

		// branch in set 3, jump in set 9
		pc_a = {6'($random(seed)), 4'h3};
		pc_b = {6'($random(seed)), 4'h9};
		tgt_a = 10'($random(seed)) | 10'd1;
		decode_entry(pc_a, tgt_a, 1'b0);
		wait_fetch_target(pc_a, tgt_a);
		decode_entry(pc_b, 10'h2f1, 1'b1);
		wait_fetch_target(pc_b, 10'h2f1);
		resolve_branch(pc_b, bt_bge, 1'b0, 1'b0);

		// walk the counter down to 0 and up to 3
		if_pc = pc_a;
		for (int i = 0; i < 4; i++)
			resolve_branch(pc_a, bt_beq, 1'b0, 1'b0);
		for (int i = 0; i < 4; i++)
			resolve_branch(pc_a, bt_beq, 1'b1, 1'b0);

		// every opcode against every flag pair
		for (int t = 0; t < 6; t++)
			for (int f = 0; f < 4; f++)
				resolve_branch(pc_a, bt_list[t], f[1], f[0]);

		// five tags into set 5, the oldest goes
		base = 6'($random(seed));
		for (int k = 0; k < 5; k++)
		begin
			ev_pc[k] = {base + 6'(7 * k), 4'h5};
			decode_entry(ev_pc[k], 10'($random(seed)) | 10'd1, 1'b0);
		end
		for (int k = 0; k < 5; k++)
			fetch_at(ev_pc[k]);

		// execute misses change nothing
		resolve_branch(ev_pc[0], bt_bne, 1'b0, 1'b0);
		resolve_branch({pc_a[9:4] ^ 6'h15, 4'h3}, bt_beq, 1'b1, 1'b0);
		resolve_branch({6'($random(seed)), 4'hc}, bt_blt, 1'b0, 1'b1);
		fetch_at(ev_pc[0]);
		fetch_at(pc_a);

		// mixed traffic over two crowded sets
		for (int k = 0; k < 8; k++)
			pool[k] = {6'($random(seed)), (k < 6) ? 4'he : 4'hf};
		for (int i = 0; i < 60; i++)
		begin
			r = $random(seed);
			if_pc = pool[r[2:0]];
			id_pc = pool[r[5:3]];
			id_branchtarget = r[24:15];
			id_is_btype = r[6];
			id_is_jump = r[7] & r[8];
			exe_pc = pool[r[11:9]];
			exe_z = r[12];
			exe_less = r[13];
			exe_btype = r[14] ? bt_list[r[27:25] % 6] : bt_none;
			@(negedge CLK);
		end
		clear_inputs();
		@(negedge CLK);

		$display("errors: fetch %0d, execute %0d", n_err_fetch, n_err_exe);
		if (n_err_fetch + n_err_exe == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* source/bht_top.sv */
`timescale 1ns/10ps

module bht_top import bht_pkg::*;
(
	input logic CLK,
	input logic rst,

	// fetch
	input logic [pc_w-1:0] if_pc,

	// decode
	input logic [pc_w-1:0] id_pc,
	input logic [pc_w-1:0] id_branchtarget,
	input logic id_is_jump,
	input logic id_is_btype,

	// execute
	input logic [pc_w-1:0] exe_pc,
	input logic exe_z,
	input logic exe_less,
	input btype_t exe_btype,

	// prediction to the pc mux
	output logic if_prediction,
	output logic [pc_w-1:0] if_pbt,

	// correction to the pc mux
	output corr_t exe_correction,
	output logic [pc_w-1:0] exe_pbt,
	output logic [pc_w-1:0] exe_cni,
	output logic flush
);

	//////////////////////////////
	// pc split
	//////////////////////////////

	logic [set_w-1:0] if_set;
	logic [set_w-1:0] id_set;
	logic [set_w-1:0] exe_set;
	logic [tag_w-1:0] if_tag;
	logic [tag_w-1:0] id_tag;
	logic [tag_w-1:0] exe_tag;

	assign if_set = if_pc[set_w-1:0];
	assign if_tag = if_pc[pc_w-1:set_w];
	assign id_set = id_pc[set_w-1:0];
	assign id_tag = id_pc[pc_w-1:set_w];
	assign exe_set = exe_pc[set_w-1:0];
	assign exe_tag = exe_pc[pc_w-1:set_w];

	// way outputs, one slice per way
	logic [n_ways-1:0] if_hit;
	logic [n_ways-1:0] id_hit;
	logic [n_ways-1:0] exe_hit;
	logic [n_ways-1:0][pc_w-1:0] if_target;
	logic [n_ways-1:0][pc_w-1:0] exe_target;
	logic [n_ways-1:0][ctr_w-1:0] if_ctr;
	logic [n_ways-1:0][ctr_w-1:0] exe_ctr;

	// allocation bus
	logic [n_ways-1:0] alloc_we;
	logic [set_w-1:0] alloc_set;
	logic [tag_w-1:0] alloc_tag;
	logic [pc_w-1:0] alloc_target;
	logic [ctr_w-1:0] alloc_ctr;

	// update bus
	logic [n_ways-1:0] upd_we;
	logic [set_w-1:0] upd_set;
	logic [ctr_w-1:0] upd_ctr;

	//////////////////////////////
	// decode allocator
	//////////////////////////////

	bht_alloc u_alloc (
		.CLK(CLK),
		.rst(rst),
		.id_pc(id_pc),
		.id_branchtarget(id_branchtarget),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.id_hit(id_hit),
		.upd_we(upd_we),
		.upd_set(upd_set),
		.alloc_we(alloc_we),
		.alloc_set(alloc_set),
		.alloc_tag(alloc_tag),
		.alloc_target(alloc_target),
		.alloc_ctr(alloc_ctr)
	);

	//////////////////////////////
	// the four ways
	//////////////////////////////

	for (genvar w = 0; w < n_ways; w++)
	begin : g_way
		bht_way u_way (
			.CLK(CLK),
			.rst(rst),
			.if_set(if_set),
			.id_set(id_set),
			.exe_set(exe_set),
			.upd_set(upd_set),
			.alloc_set(alloc_set),
			.if_tag(if_tag),
			.id_tag(id_tag),
			.exe_tag(exe_tag),
			.alloc_tag(alloc_tag),
			.alloc_target(alloc_target),
			.alloc_ctr(alloc_ctr),
			.upd_ctr(upd_ctr),
			.alloc_we(alloc_we[w]),
			.upd_we(upd_we[w]),
			.if_hit(if_hit[w]),
			.id_hit(id_hit[w]),
			.exe_hit(exe_hit[w]),
			.if_target(if_target[w]),
			.exe_target(exe_target[w]),
			.if_ctr(if_ctr[w]),
			.exe_ctr(exe_ctr[w])
		);
	end

	//////////////////////////////
	// hit muxes and execute
	//////////////////////////////

	bht_resolve u_resolve (
		.CLK(CLK),
		.rst(rst),
		.if_hit(if_hit),
		.exe_hit(exe_hit),
		.if_target(if_target),
		.exe_target(exe_target),
		.if_ctr(if_ctr),
		.exe_ctr(exe_ctr),
		.exe_pc(exe_pc),
		.exe_z(exe_z),
		.exe_less(exe_less),
		.exe_btype(exe_btype),
		.if_prediction(if_prediction),
		.if_pbt(if_pbt),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni),
		.exe_correction(exe_correction),
		.flush(flush),
		.upd_we(upd_we),
		.upd_set(upd_set),
		.upd_ctr(upd_ctr)
	);

endmodule

/* source/bht_resolve.sv */
`timescale 1ns/10ps

module bht_resolve import bht_pkg::*;
(
	// clock and reset for the checks only
	input logic CLK,
	input logic rst,

	// per way lookup results
	input logic [n_ways-1:0] if_hit,
	input logic [n_ways-1:0] exe_hit,
	input logic [n_ways-1:0][pc_w-1:0] if_target,
	input logic [n_ways-1:0][pc_w-1:0] exe_target,
	input logic [n_ways-1:0][ctr_w-1:0] if_ctr,
	input logic [n_ways-1:0][ctr_w-1:0] exe_ctr,

	// execute stage branch
	input logic [pc_w-1:0] exe_pc,
	input logic exe_z,
	input logic exe_less,
	input btype_t exe_btype,

	// fetch prediction
	output logic if_prediction,
	output logic [pc_w-1:0] if_pbt,

	// execute fixup
	output logic [pc_w-1:0] exe_pbt,
	output logic [pc_w-1:0] exe_cni,
	output corr_t exe_correction,
	output logic flush,

	// counter write back
	output logic [n_ways-1:0] upd_we,
	output logic [set_w-1:0] upd_set,
	output logic [ctr_w-1:0] upd_ctr
);

	logic [ctr_w-1:0] if_sel_ctr;
	logic [ctr_w-1:0] exe_sel_ctr;
	logic taken;
	logic active;
	logic mispredict;

	//////////////////////////////
	// fetch
	//////////////////////////////

	// or-mux of the hitting way, zero on a miss
	always_comb
	begin
		if_pbt = '0;
		if_sel_ctr = '0;
		for (int w = 0; w < n_ways; w++)
		begin
			if (if_hit[w])
			begin
				if_pbt = if_target[w];
				if_sel_ctr = if_ctr[w];
			end
		end
	end

	// counter msb is the taken prediction
	assign if_prediction = if_sel_ctr[ctr_w-1];

	//////////////////////////////
	// execute
	//////////////////////////////

	always_comb
	begin
		exe_pbt = '0;
		exe_sel_ctr = '0;
		for (int w = 0; w < n_ways; w++)
		begin
			if (exe_hit[w])
			begin
				exe_pbt = exe_target[w];
				exe_sel_ctr = exe_ctr[w];
			end
		end
	end

	// branch outcome from the alu flags
	always_comb
	begin
		case (exe_btype)
			bt_beq: taken = exe_z;
			bt_bne: taken = !exe_z;
			bt_blt, bt_bltu: taken = exe_less;
			bt_bge, bt_bgeu: taken = !exe_less;
			default: taken = 1'b0;
		endcase
	end

	// misses at execute are left alone
	assign active = (|exe_hit) && (exe_btype != bt_none);
	assign mispredict = active && (exe_sel_ctr[ctr_w-1] != taken);

	// fall through address
	assign exe_cni = exe_pc + pc_w'(4);

	assign exe_correction = !mispredict ? corr_none : (taken ? corr_pbt : corr_cni);
	assign flush = (exe_correction != corr_none);

	//////////////////////////////
	// counter update
	//////////////////////////////

	assign upd_we = active ? exe_hit : '0;
	assign upd_set = exe_pc[set_w-1:0];

	// saturate at 3 going up and at 0 going down
	always_comb
	begin
		if (taken)
		begin
			upd_ctr = (&exe_sel_ctr) ? exe_sel_ctr : exe_sel_ctr + ctr_w'(1);
		end
		else
		begin
			upd_ctr = (~|exe_sel_ctr) ? exe_sel_ctr : exe_sel_ctr - ctr_w'(1);
		end
	end

	// a tag lives in at most one way of its set
	a_if_hit_onehot: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(if_hit));
	a_exe_hit_onehot: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(exe_hit));
	// decoder hands over at most one branch opcode
	a_btype_onehot: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(exe_btype));

endmodule

/* source/bht_alloc.sv */
`timescale 1ns/10ps

module bht_alloc import bht_pkg::*;
(
	input logic CLK,
	input logic rst,

	// decode stage instruction
	input logic [pc_w-1:0] id_pc,
	input logic [pc_w-1:0] id_branchtarget,
	input logic id_is_jump,
	input logic id_is_btype,

	// per way hit at decode
	input logic [n_ways-1:0] id_hit,

	// execute side writes, which can displace an allocation
	input logic [n_ways-1:0] upd_we,
	input logic [set_w-1:0] upd_set,

	// write to the ways
	output logic [n_ways-1:0] alloc_we,
	output logic [set_w-1:0] alloc_set,
	output logic [tag_w-1:0] alloc_tag,
	output logic [pc_w-1:0] alloc_target,
	output logic [ctr_w-1:0] alloc_ctr
);

	//////////////////////////////
	// fifo replacement pointers
	//////////////////////////////

	// one pointer per set, names the oldest way
	logic [way_w-1:0] fifo_ptr [n_sets];
	logic [way_w-1:0] cur_ptr;

	// decode wants an entry
	logic alloc_req;
	// counter update took the same way and set this cycle
	logic displaced;

	//////////////////////////////
	// entry fields
	//////////////////////////////

	assign alloc_set = id_pc[set_w-1:0];
	assign alloc_tag = id_pc[pc_w-1:set_w];
	assign alloc_target = id_branchtarget;

	// jumps start strongly taken
	assign alloc_ctr = id_is_jump ? ctr_init_jump : ctr_init_branch;

	// only control transfers that are not yet in the table
	assign alloc_req = (id_is_jump || id_is_btype) && !(|id_hit);

	assign cur_ptr = fifo_ptr[alloc_set];

	// decode pointer into a one-hot way enable
	always_comb
	begin
		alloc_we = '0;
		if (alloc_req)
		begin
			alloc_we[cur_ptr] = 1'b1;
		end
	end

	// same rule the way uses to drop a write
	assign displaced = (|(alloc_we & upd_we)) && (upd_set == alloc_set);

	//////////////////////////////
	// pointer advance
	//////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			for (int s = 0; s < n_sets; s++)
			begin
				fifo_ptr[s] <= '0;
			end
		end
		else if (alloc_req && !displaced)
		begin
			// wraps 3 -> 0
			fifo_ptr[alloc_set] <= cur_ptr + way_w'(1);
		end
	end

	// never write two ways for one branch
	a_alloc_onehot: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(alloc_we));

endmodule

/* source/bht_way.sv */
`timescale 1ns/10ps

module bht_way import bht_pkg::*;
(
	input logic CLK,
	input logic rst,

	// set indices of the three lookups and both writers
	input logic [set_w-1:0] if_set,
	input logic [set_w-1:0] id_set,
	input logic [set_w-1:0] exe_set,
	input logic [set_w-1:0] upd_set,
	input logic [set_w-1:0] alloc_set,

	// tags to compare against
	input logic [tag_w-1:0] if_tag,
	input logic [tag_w-1:0] id_tag,
	input logic [tag_w-1:0] exe_tag,
	input logic [tag_w-1:0] alloc_tag,

	// new entry payload from decode
	input logic [pc_w-1:0] alloc_target,
	input logic [ctr_w-1:0] alloc_ctr,
	input logic [ctr_w-1:0] upd_ctr,
	input logic alloc_we,
	input logic upd_we,

	// lookup results
	output logic if_hit,
	output logic id_hit,
	output logic exe_hit,
	output logic [pc_w-1:0] if_target,
	output logic [pc_w-1:0] exe_target,
	output logic [ctr_w-1:0] if_ctr,
	output logic [ctr_w-1:0] exe_ctr
);

	//////////////////////////////
	// entry storage
	//////////////////////////////

	// valid bits are control state, the rest is payload
	logic [n_sets-1:0] valid;
	logic [tag_w-1:0] tag_mem [n_sets];
	logic [pc_w-1:0] target_mem [n_sets];
	logic [ctr_w-1:0] ctr_mem [n_sets];

	// allocation survives only if no counter update hits the same set
	logic alloc_go;

	assign alloc_go = alloc_we && !(upd_we && (upd_set == alloc_set));

	//////////////////////////////
	// read ports
	//////////////////////////////

	// tag compare, qualified by valid
	assign if_hit = valid[if_set] && (tag_mem[if_set] == if_tag);
	assign id_hit = valid[id_set] && (tag_mem[id_set] == id_tag);
	assign exe_hit = valid[exe_set] && (tag_mem[exe_set] == exe_tag);

	// raw data, the resolver picks by hit
	assign if_target = target_mem[if_set];
	assign if_ctr = ctr_mem[if_set];
	assign exe_target = target_mem[exe_set];
	assign exe_ctr = ctr_mem[exe_set];

	//////////////////////////////
	// write port
	//////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			valid <= '0;
		end
		else if (alloc_go)
		begin
			valid[alloc_set] <= 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		// whole entry on allocation
		if (alloc_go)
		begin
			tag_mem[alloc_set] <= alloc_tag;
			target_mem[alloc_set] <= alloc_target;
			ctr_mem[alloc_set] <= alloc_ctr;
		end
		// counter only on update
		if (upd_we)
		begin
			ctr_mem[upd_set] <= upd_ctr;
		end
	end

	// resolver only updates entries that hit at execute
	a_upd_valid: assert property (@(posedge CLK) disable iff (rst)
		upd_we |-> valid[upd_set]);

endmodule

/* source/bht_pkg.sv */
package bht_pkg;

	//////////////////////////////
	// pc and table geometry
	//////////////////////////////

	// program counter width
	localparam int pc_w = 10;

	// set index is pc[3:0], tag is pc[9:4]
	localparam int set_w = 4;
	localparam int tag_w = 6;

	// 16 sets of 4 ways
	localparam int n_sets = 16;
	localparam int n_ways = 4;

	// way index, also the width of a fifo pointer
	localparam int way_w = 2;

	//////////////////////////////
	// saturating counter
	//////////////////////////////

	localparam int ctr_w = 2;

	// conditional branches start weakly taken
	localparam logic [ctr_w-1:0] ctr_init_branch = 2'd2;
	// jumps always go, so start strongly taken
	localparam logic [ctr_w-1:0] ctr_init_jump = 2'd3;

	//////////////////////////////
	// execute stage encodings
	//////////////////////////////

	// one-hot branch opcode, msb is beq
	typedef enum logic [5:0] {
		bt_none = 6'b000000,
		bt_beq  = 6'b100000,
		bt_bne  = 6'b010000,
		bt_blt  = 6'b001000,
		bt_bge  = 6'b000100,
		bt_bltu = 6'b000010,
		bt_bgeu = 6'b000001
	} btype_t;

	// next pc fixup from execute
	// cni redirects to pc+4, pbt to the stored target
	typedef enum logic [1:0] {
		corr_none = 2'b00,
		corr_cni  = 2'b10,
		corr_pbt  = 2'b11
	} corr_t;

endpackage
